// File: design/shared_mem.sv
`timescale 1ns/10ps
`default_nettype none

module shared_mem (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  smem_pkg::lane_mask_t                 req_valid,
    input  wire  smem_pkg::lane_mask_t                 req_rw,
    input  wire  smem_pkg::addr_t   [smem_pkg::NUM_REQS-1:0]  req_addr,
    input  wire  smem_pkg::byteen_t [smem_pkg::NUM_REQS-1:0]  req_byteen,
    input  wire  smem_pkg::word_t   [smem_pkg::NUM_REQS-1:0]  req_data,
    input  wire  smem_pkg::tag_t    [smem_pkg::NUM_REQS-1:0]  req_tag,
    output smem_pkg::lane_mask_t                       req_ready,
    output smem_pkg::lane_mask_t                       rsp_valid,
    output smem_pkg::word_t [smem_pkg::NUM_REQS-1:0]          rsp_data,
    output smem_pkg::tag_t  [smem_pkg::NUM_REQS-1:0]          rsp_tag,
    input  wire  smem_pkg::lane_mask_t                 rsp_ready,
    output smem_pkg::perf_t                            perf_reads,
    output smem_pkg::perf_t                            perf_writes,
    output smem_pkg::perf_t                            perf_rsp_stalls
);

    wire                                              queue_in_valid;
    wire                                              queue_in_ready;
    wire smem_pkg::bank_mask_t                        sel_valid;
    wire smem_pkg::bank_mask_t                        sel_rw;
    wire smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0] sel_line;
    wire smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0] sel_byteen;
    wire smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] sel_data;
    wire smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] sel_tag;
    wire smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] sel_lane;

    wire                                              head_valid;
    wire                                              queue_pop;
    wire smem_pkg::bank_mask_t                        head_bank_valid;
    wire smem_pkg::bank_mask_t                        head_rw;
    wire smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0] head_line;
    wire smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0] head_byteen;
    wire smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] head_data;
    wire smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] head_tag;
    wire smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] head_lane;

    wire smem_pkg::bank_mask_t                        bank_rsp_valid;
    wire smem_pkg::bank_mask_t                        bank_rsp_ready;
    wire smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] bank_rsp_data;
    wire smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] bank_rsp_tag;
    wire smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] bank_rsp_lane;

    smem_bank_sel bank_sel (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_rw         (req_rw),
        .req_addr       (req_addr),
        .req_byteen     (req_byteen),
        .req_data       (req_data),
        .req_tag        (req_tag),
        .queue_in_ready (queue_in_ready),
        .req_ready      (req_ready),
        .queue_in_valid (queue_in_valid),
        .bank_valid     (sel_valid),
        .bank_rw        (sel_rw),
        .bank_line      (sel_line),
        .bank_byteen    (sel_byteen),
        .bank_data      (sel_data),
        .bank_tag       (sel_tag),
        .bank_lane      (sel_lane)
    );

    smem_req_queue req_queue (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (queue_in_valid),
        .bank_valid      (sel_valid),
        .bank_rw         (sel_rw),
        .bank_line       (sel_line),
        .bank_byteen     (sel_byteen),
        .bank_data       (sel_data),
        .bank_tag        (sel_tag),
        .bank_lane       (sel_lane),
        .queue_pop       (queue_pop),
        .in_ready        (queue_in_ready),
        .out_valid       (head_valid),
        .out_bank_valid  (head_bank_valid),
        .out_bank_rw     (head_rw),
        .out_bank_line   (head_line),
        .out_bank_byteen (head_byteen),
        .out_bank_data   (head_data),
        .out_bank_tag    (head_tag),
        .out_bank_lane   (head_lane)
    );

    smem_bank_array bank_array (
        .clk            (clk),
        .reset          (reset),
        .head_valid     (head_valid),
        .bank_valid     (head_bank_valid),
        .bank_rw        (head_rw),
        .bank_line      (head_line),
        .bank_byteen    (head_byteen),
        .bank_data      (head_data),
        .bank_tag       (head_tag),
        .bank_lane      (head_lane),
        .bank_rsp_ready (bank_rsp_ready),
        .queue_pop      (queue_pop),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_data  (bank_rsp_data),
        .bank_rsp_tag   (bank_rsp_tag),
        .bank_rsp_lane  (bank_rsp_lane)
    );

    smem_rsp_merge rsp_merge (
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_data  (bank_rsp_data),
        .bank_rsp_tag   (bank_rsp_tag),
        .bank_rsp_lane  (bank_rsp_lane),
        .rsp_ready      (rsp_ready),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_tag        (rsp_tag)
    );

    smem_perf_counters perf_counters (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_rw          (req_rw),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .perf_reads      (perf_reads),
        .perf_writes     (perf_writes),
        .perf_rsp_stalls (perf_rsp_stalls)
    );

endmodule

`default_nettype wire

// File: design/smem_bank_array.sv
`timescale 1ns/10ps
`default_nettype none

module smem_bank_array (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        head_valid,
    input  wire  smem_pkg::bank_mask_t                 bank_valid,
    input  wire  smem_pkg::bank_mask_t                 bank_rw,
    input  wire  smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0] bank_line,
    input  wire  smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0] bank_byteen,
    input  wire  smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] bank_data,
    input  wire  smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] bank_tag,
    input  wire  smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] bank_lane,
    input  wire  smem_pkg::bank_mask_t                 bank_rsp_ready,
    output logic                                       queue_pop,
    output smem_pkg::bank_mask_t                       bank_rsp_valid,
    output smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0]       bank_rsp_data,
    output smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0]       bank_rsp_tag,
    output smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0]       bank_rsp_lane
);

    smem_pkg::bank_mask_t read_mask;
    smem_pkg::bank_mask_t sent_q;
    smem_pkg::bank_mask_t rsp_fire;
    smem_pkg::bank_mask_t done_n;

    assign read_mask = {smem_pkg::NUM_BANKS{head_valid}} & bank_valid & ~bank_rw;

    for (genvar b = 0; b < smem_pkg::NUM_BANKS; b++) begin : g_bank
        smem_pkg::byteen_t wren;

        // Rewritten with the same data each cycle the entry waits at the head
        assign wren = bank_byteen[b]
                    & {smem_pkg::WORD_BYTES{head_valid && bank_valid[b] && bank_rw[b]}};

        smem_bank_ram ram (
            .clk   (clk),
            .line  (bank_line[b]),
            .wren  (wren),
            .wdata (bank_data[b]),
            .rdata (bank_rsp_data[b])
        );

        assign bank_rsp_tag[b]  = bank_tag[b];
        assign bank_rsp_lane[b] = bank_lane[b];
    end

    // Banks already answered stay quiet until the entry pops
    assign bank_rsp_valid = read_mask & ~sent_q;
    assign rsp_fire       = bank_rsp_valid & bank_rsp_ready;
    assign done_n         = sent_q | rsp_fire;

    // Write-only entries pop at once since read_mask is zero
    assign queue_pop = head_valid && (done_n == read_mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_q <= '0;
        end else if (queue_pop) begin
            sent_q <= '0;
        end else begin
            sent_q <= done_n;
        end
    end

endmodule

`default_nettype wire

// File: design/smem_bank_ram.sv
`timescale 1ns/10ps
`default_nettype none

module smem_bank_ram (
    input  wire                     clk,
    input  wire  smem_pkg::line_t   line,
    input  wire  smem_pkg::byteen_t wren,
    input  wire  smem_pkg::word_t   wdata,
    output smem_pkg::word_t         rdata
);

    smem_pkg::word_t mem [smem_pkg::LINES_PER_BANK];

    always_ff @(posedge clk) begin
        for (int i = 0; i < smem_pkg::WORD_BYTES; i++) begin
            if (wren[i]) begin
                mem[line][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // Asynchronous read of the head line
    assign rdata = mem[line];

endmodule

`default_nettype wire

// File: design/smem_bank_sel.sv
`timescale 1ns/10ps
`default_nettype none

module smem_bank_sel (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  smem_pkg::lane_mask_t                 req_valid,
    input  wire  smem_pkg::lane_mask_t                 req_rw,
    input  wire  smem_pkg::addr_t   [smem_pkg::NUM_REQS-1:0]  req_addr,
    input  wire  smem_pkg::byteen_t [smem_pkg::NUM_REQS-1:0]  req_byteen,
    input  wire  smem_pkg::word_t   [smem_pkg::NUM_REQS-1:0]  req_data,
    input  wire  smem_pkg::tag_t    [smem_pkg::NUM_REQS-1:0]  req_tag,
    input  wire                                        queue_in_ready,
    output smem_pkg::lane_mask_t                       req_ready,
    output logic                                       queue_in_valid,
    output smem_pkg::bank_mask_t                       bank_valid,
    output smem_pkg::bank_mask_t                       bank_rw,
    output smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0]       bank_line,
    output smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0]       bank_byteen,
    output smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0]       bank_data,
    output smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0]       bank_tag,
    output smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0]       bank_lane
);

    smem_pkg::lane_mask_t win;

    always_comb begin
        bank_valid  = '0;
        bank_rw     = '0;
        bank_line   = '0;
        bank_byteen = '0;
        bank_data   = '0;
        bank_tag    = '0;
        bank_lane   = '0;
        win         = '0;
        // Lowest valid lane takes each bank
        for (int b = 0; b < smem_pkg::NUM_BANKS; b++) begin
            for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
                if (!bank_valid[b] && req_valid[l]
                    && req_addr[l][smem_pkg::BANK_BITS-1:0] == b[smem_pkg::BANK_BITS-1:0]) begin
                    bank_valid[b]  = 1'b1;
                    bank_rw[b]     = req_rw[l];
                    bank_line[b]   = req_addr[l][smem_pkg::ADDR_WIDTH-1:smem_pkg::BANK_BITS];
                    bank_byteen[b] = req_byteen[l];
                    bank_data[b]   = req_data[l];
                    bank_tag[b]    = req_tag[l];
                    bank_lane[b]   = l[smem_pkg::LANE_BITS-1:0];
                    win[l]         = 1'b1;
                end
            end
        end
    end

    assign queue_in_valid = |req_valid;

    // Losers of a bank conflict stall and retry next cycle
    assign req_ready = win & {smem_pkg::NUM_REQS{queue_in_ready}};

endmodule

`default_nettype wire

// File: design/smem_perf_counters.sv
`timescale 1ns/10ps
`default_nettype none

module smem_perf_counters (
    input  wire                          clk,
    input  wire                          reset,
    input  wire  smem_pkg::lane_mask_t   req_valid,
    input  wire  smem_pkg::lane_mask_t   req_ready,
    input  wire  smem_pkg::lane_mask_t   req_rw,
    input  wire  smem_pkg::lane_mask_t   rsp_valid,
    input  wire  smem_pkg::lane_mask_t   rsp_ready,
    output smem_pkg::perf_t              perf_reads,
    output smem_pkg::perf_t              perf_writes,
    output smem_pkg::perf_t              perf_rsp_stalls
);

    smem_pkg::lane_mask_t accepted;
    smem_pkg::perf_t      reads_now;
    smem_pkg::perf_t      writes_now;

    assign accepted = req_valid & req_ready;

    // Population counts of this cycle's accepted requests
    always_comb begin
        reads_now  = '0;
        writes_now = '0;
        for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
            reads_now  = reads_now + smem_pkg::perf_t'(accepted[l] & ~req_rw[l]);
            writes_now = writes_now + smem_pkg::perf_t'(accepted[l] & req_rw[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_reads      <= '0;
            perf_writes     <= '0;
            perf_rsp_stalls <= '0;
        end else begin
            perf_reads      <= perf_reads + reads_now;
            perf_writes     <= perf_writes + writes_now;
            perf_rsp_stalls <= perf_rsp_stalls
                             + smem_pkg::perf_t'(|(rsp_valid & ~rsp_ready));
        end
    end

endmodule

`default_nettype wire

// File: design/smem_pkg.sv
`default_nettype none

package smem_pkg;

    localparam int NUM_REQS       = 4;
    localparam int NUM_BANKS      = 2;
    localparam int WORD_BYTES     = 4;
    localparam int WORD_WIDTH     = 32;
    localparam int LINES_PER_BANK = 64;
    localparam int BANK_BITS      = 1;
    localparam int LINE_BITS      = 6;
    localparam int ADDR_WIDTH     = 7;
    localparam int TAG_WIDTH      = 8;
    localparam int LANE_BITS      = 2;
    localparam int QUEUE_DEPTH    = 2;
    localparam int PERF_WIDTH     = 16;

    typedef logic [WORD_WIDTH-1:0] word_t;
    // Low bit picks the bank and upper bits the line
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [WORD_BYTES-1:0] byteen_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [LANE_BITS-1:0]  lane_t;
    typedef logic [PERF_WIDTH-1:0] perf_t;
    typedef logic [NUM_REQS-1:0]   lane_mask_t;
    typedef logic [NUM_BANKS-1:0]  bank_mask_t;

endpackage

`default_nettype wire

// File: design/smem_req_queue.sv
`timescale 1ns/10ps
`default_nettype none

module smem_req_queue (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        in_valid,
    input  wire  smem_pkg::bank_mask_t                 bank_valid,
    input  wire  smem_pkg::bank_mask_t                 bank_rw,
    input  wire  smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0] bank_line,
    input  wire  smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0] bank_byteen,
    input  wire  smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] bank_data,
    input  wire  smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] bank_tag,
    input  wire  smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] bank_lane,
    input  wire                                        queue_pop,
    output logic                                       in_ready,
    output logic                                       out_valid,
    output smem_pkg::bank_mask_t                       out_bank_valid,
    output smem_pkg::bank_mask_t                       out_bank_rw,
    output smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0]       out_bank_line,
    output smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0]       out_bank_byteen,
    output smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0]       out_bank_data,
    output smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0]       out_bank_tag,
    output smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0]       out_bank_lane
);

    logic [1:0] count;
    logic       push;
    logic       pop;

    // Second slot behind the registered head
    smem_pkg::bank_mask_t                        valid_1;
    smem_pkg::bank_mask_t                        rw_1;
    smem_pkg::line_t   [smem_pkg::NUM_BANKS-1:0] line_1;
    smem_pkg::byteen_t [smem_pkg::NUM_BANKS-1:0] byteen_1;
    smem_pkg::word_t   [smem_pkg::NUM_BANKS-1:0] data_1;
    smem_pkg::tag_t    [smem_pkg::NUM_BANKS-1:0] tag_1;
    smem_pkg::lane_t   [smem_pkg::NUM_BANKS-1:0] lane_1;

    assign in_ready  = (count != 2'(smem_pkg::QUEUE_DEPTH));
    assign out_valid = (count != 2'd0);
    assign push      = in_valid && in_ready;
    assign pop       = queue_pop && out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 2'd0;
        end else begin
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push && (count == 2'd0 || (count == 2'd1 && pop))) begin
            out_bank_valid  <= bank_valid;
            out_bank_rw     <= bank_rw;
            out_bank_line   <= bank_line;
            out_bank_byteen <= bank_byteen;
            out_bank_data   <= bank_data;
            out_bank_tag    <= bank_tag;
            out_bank_lane   <= bank_lane;
        end else if (pop && count == 2'd2) begin
            out_bank_valid  <= valid_1;
            out_bank_rw     <= rw_1;
            out_bank_line   <= line_1;
            out_bank_byteen <= byteen_1;
            out_bank_data   <= data_1;
            out_bank_tag    <= tag_1;
            out_bank_lane   <= lane_1;
        end
        if (push && count == 2'd1 && !pop) begin
            valid_1  <= bank_valid;
            rw_1     <= bank_rw;
            line_1   <= bank_line;
            byteen_1 <= bank_byteen;
            data_1   <= bank_data;
            tag_1    <= bank_tag;
            lane_1   <= bank_lane;
        end
    end

endmodule

`default_nettype wire

// File: design/smem_rsp_merge.sv
`timescale 1ns/10ps
`default_nettype none

module smem_rsp_merge (
    input  wire  smem_pkg::bank_mask_t                 bank_rsp_valid,
    input  wire  smem_pkg::word_t [smem_pkg::NUM_BANKS-1:0]   bank_rsp_data,
    input  wire  smem_pkg::tag_t  [smem_pkg::NUM_BANKS-1:0]   bank_rsp_tag,
    input  wire  smem_pkg::lane_t [smem_pkg::NUM_BANKS-1:0]   bank_rsp_lane,
    input  wire  smem_pkg::lane_mask_t                 rsp_ready,
    output smem_pkg::bank_mask_t                       bank_rsp_ready,
    output smem_pkg::lane_mask_t                       rsp_valid,
    output smem_pkg::word_t [smem_pkg::NUM_REQS-1:0]          rsp_data,
    output smem_pkg::tag_t  [smem_pkg::NUM_REQS-1:0]          rsp_tag
);

    // Both banks of one entry always serve different lanes
    always_comb begin
        rsp_valid = '0;
        rsp_data  = '0;
        rsp_tag   = '0;
        for (int b = 0; b < smem_pkg::NUM_BANKS; b++) begin
            if (bank_rsp_valid[b]) begin
                rsp_valid[bank_rsp_lane[b]] = 1'b1;
                rsp_data[bank_rsp_lane[b]]  = bank_rsp_data[b];
                rsp_tag[bank_rsp_lane[b]]   = bank_rsp_tag[b];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < smem_pkg::NUM_BANKS; b++) begin
            bank_rsp_ready[b] = rsp_ready[bank_rsp_lane[b]];
        end
    end

endmodule

`default_nettype wire

// File: list.f
design/smem_pkg.sv
design/smem_bank_sel.sv
design/smem_req_queue.sv
design/smem_bank_ram.sv
design/smem_bank_array.sv
design/smem_rsp_merge.sv
design/smem_perf_counters.sv
design/shared_mem.sv
verif/shared_mem_sva.sv
verif/shared_mem_tb.sv

// File: verif/shared_mem_sva.sv
`timescale 1ns/10ps
`default_nettype none

module shared_mem_sva (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  smem_pkg::lane_mask_t                 rsp_valid,
    input  wire  smem_pkg::lane_mask_t                 rsp_ready,
    input  wire  smem_pkg::word_t [smem_pkg::NUM_REQS-1:0]    rsp_data,
    input  wire  smem_pkg::tag_t  [smem_pkg::NUM_REQS-1:0]    rsp_tag
);

    int fail_count = 0;

    // Queue is empty right after reset
    a_idle_after_reset: assert property (@(posedge clk) reset |=> rsp_valid == '0)
        else begin
            fail_count++;
            $error("rsp_valid high in the cycle after reset");
        end

    for (genvar l = 0; l < smem_pkg::NUM_REQS; l++) begin : g_lane
        // Stalled response holds until the lane takes it
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[l] && !rsp_ready[l]
            |=> rsp_valid[l] && $stable(rsp_data[l]) && $stable(rsp_tag[l]))
            else begin
                fail_count++;
                $error("lane %0d response dropped or changed while stalled", l);
            end
    end

endmodule

`default_nettype wire

// File: verif/shared_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module shared_mem_tb;

    localparam int RESET_CYCLES      = 16;
    localparam int FILL_PER_LANE     = 32;
    localparam int RAND_PER_LANE     = 60;
    localparam int CONFLICT_PER_LANE = 12;
    localparam int TOTAL_TXNS        = smem_pkg::NUM_REQS
                                     * (FILL_PER_LANE + RAND_PER_LANE + CONFLICT_PER_LANE);

    typedef enum {FILL, RANDOM, CONFLICT} traffic_t;

    logic                                       clk;
    logic                                       reset;
    smem_pkg::lane_mask_t                       req_valid;
    smem_pkg::lane_mask_t                       req_rw;
    smem_pkg::addr_t   [smem_pkg::NUM_REQS-1:0] req_addr;
    smem_pkg::byteen_t [smem_pkg::NUM_REQS-1:0] req_byteen;
    smem_pkg::word_t   [smem_pkg::NUM_REQS-1:0] req_data;
    smem_pkg::tag_t    [smem_pkg::NUM_REQS-1:0] req_tag;
    smem_pkg::lane_mask_t                       req_ready;
    smem_pkg::lane_mask_t                       rsp_valid;
    smem_pkg::word_t   [smem_pkg::NUM_REQS-1:0] rsp_data;
    smem_pkg::tag_t    [smem_pkg::NUM_REQS-1:0] rsp_tag;
    smem_pkg::lane_mask_t                       rsp_ready;
    smem_pkg::perf_t                            perf_reads;
    smem_pkg::perf_t                            perf_writes;
    smem_pkg::perf_t                            perf_rsp_stalls;

    // Byte-level reference memory and per-lane expected reads
    logic [7:0]           ref_mem [2**(smem_pkg::ADDR_WIDTH+2)];
    smem_pkg::word_t      exp_data [smem_pkg::NUM_REQS][$];
    smem_pkg::tag_t       exp_tag  [smem_pkg::NUM_REQS][$];
    smem_pkg::lane_mask_t taken = '0;
    integer               seed;
    int                   error_count = 0;
    int                   check_count = 0;
    int                   n_reads = 0;
    int                   n_writes = 0;
    int                   n_stalls = 0;

    shared_mem dut (.*);

    bind shared_mem shared_mem_sva sva (
        .clk       (clk),
        .reset     (reset),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic smem_pkg::word_t fill_word(input smem_pkg::addr_t a);
        return {{1'b0, a}, 8'h5a ^ {1'b0, a}, ~{1'b0, a}, {1'b1, a}};
    endfunction

    function automatic smem_pkg::word_t ref_word(input smem_pkg::addr_t a);
        smem_pkg::word_t w;
        for (int i = 0; i < smem_pkg::WORD_BYTES; i++) begin
            w[i*8 +: 8] = ref_mem[{a, 2'(i)}];
        end
        return w;
    endfunction

    // Lowest valid lane per bank bit
    function automatic smem_pkg::lane_mask_t lowest_per_bank();
        smem_pkg::lane_mask_t w;
        smem_pkg::bank_mask_t claimed;
        w = '0;
        claimed = '0;
        for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
            if (req_valid[l] && !claimed[req_addr[l][0]]) begin
                claimed[req_addr[l][0]] = 1'b1;
                w[l] = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
            n += exp_data[l].size();
        end
        return n;
    endfunction

    task automatic check_response(input int l);
        smem_pkg::word_t want_data;
        smem_pkg::tag_t  want_tag;
        check_count++;
        assert (exp_data[l].size() > 0) else begin
            error_count++;
            $display("Lane %0d returned a response with no read outstanding at %0t", l, $time);
        end
        if (exp_data[l].size() > 0) begin
            want_data = exp_data[l].pop_front();
            want_tag  = exp_tag[l].pop_front();
            assert (rsp_tag[l] === want_tag && rsp_data[l] === want_data) else begin
                error_count++;
                $display("ERROR %0t: lane %0d got tag %h data %h, expected tag %h data %h",
                         $time, l, rsp_tag[l], rsp_data[l], want_tag, want_data);
            end
        end
    endtask

    task automatic record_request(input int l);
        if (req_rw[l]) begin
            n_writes++;
            for (int i = 0; i < smem_pkg::WORD_BYTES; i++) begin
                if (req_byteen[l][i]) begin
                    ref_mem[{req_addr[l], 2'(i)}] = req_data[l][i*8 +: 8];
                end
            end
        end else begin
            n_reads++;
            exp_data[l].push_back(ref_word(req_addr[l]));
            exp_tag[l].push_back(req_tag[l]);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            taken = '0;
        end else begin
            taken = req_valid & req_ready;
            check_count++;
            assert (req_ready == '0 || req_ready == lowest_per_bank()) else begin
                error_count++;
                $display("ERROR %0t: req_ready %b with req_valid %b, expected winners %b",
                         $time, req_ready, req_valid, lowest_per_bank());
            end
            for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
                if (rsp_valid[l] && rsp_ready[l]) begin
                    check_response(l);
                end
                if (taken[l]) begin
                    record_request(l);
                end
            end
            if (|(rsp_valid & ~rsp_ready)) begin
                n_stalls++;
            end
        end
    end

    task automatic make_request(input int l, input traffic_t mode, input int idx);
        logic [31:0]     rnd_a;
        logic [31:0]     rnd_d;
        smem_pkg::addr_t a;
        rnd_a = $random(seed);
        rnd_d = $random(seed);
        req_rw[l]     = rnd_a[7];
        req_byteen[l] = rnd_a[11:8];
        req_data[l]   = rnd_d;
        case (mode)
            FILL: begin
                a             = smem_pkg::addr_t'(l + smem_pkg::NUM_REQS * idx);
                req_rw[l]     = 1'b1;
                req_byteen[l] = '1;
                req_data[l]   = fill_word(a);
            end
            RANDOM:  a = rnd_a[6:0];
            // Every lane aims at bank 0
            default: a = {rnd_a[5:0], 1'b0};
        endcase
        req_addr[l]  = a;
        req_tag[l]   = {smem_pkg::lane_t'(l), idx[5:0]};
        req_valid[l] = 1'b1;
    endtask

    task automatic run_traffic(input traffic_t mode, input int per_lane);
        int          left [smem_pkg::NUM_REQS];
        logic [31:0] rnd;
        bit          busy;
        foreach (left[l]) left[l] = per_lane;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int l = 0; l < smem_pkg::NUM_REQS; l++) begin
                if (req_valid[l] && taken[l]) begin
                    req_valid[l] = 1'b0;
                end
                rnd = $random(seed);
                if (!req_valid[l] && left[l] > 0 && (mode != RANDOM || rnd[1:0] != 2'b00)) begin
                    make_request(l, mode, per_lane - left[l]);
                    left[l]--;
                end
                if (req_valid[l] || left[l] > 0) begin
                    busy = 1'b1;
                end
            end
            rnd = $random(seed);
            rsp_ready = (mode == RANDOM) ? (rnd[3:0] | rnd[7:4]) : '1;
        end
    endtask

    initial begin
        seed       = 32'h31cf_0bca;
        reset      = 1'b1;
        req_valid  = '0;
        req_rw     = '0;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_tag    = '0;
        rsp_ready  = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_count++;
        assert (rsp_valid == '0 && perf_reads == '0 && perf_writes == '0
                && perf_rsp_stalls == '0) else begin
            error_count++;
            $display("ERROR %0t: not idle after reset, rsp_valid %b counters %0d %0d %0d",
                     $time, rsp_valid, perf_reads, perf_writes, perf_rsp_stalls);
        end
        run_traffic(FILL, FILL_PER_LANE);
        run_traffic(RANDOM, RAND_PER_LANE);
        run_traffic(CONFLICT, CONFLICT_PER_LANE);
        rsp_ready = '1;
        while (outstanding() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        check_count++;
        assert (perf_reads == smem_pkg::perf_t'(n_reads)
                && perf_writes == smem_pkg::perf_t'(n_writes)
                && perf_rsp_stalls == smem_pkg::perf_t'(n_stalls)) else begin
            error_count++;
            $display("ERROR %0t: counters %0d %0d %0d, expected %0d %0d %0d", $time,
                     perf_reads, perf_writes, perf_rsp_stalls, n_reads, n_writes, n_stalls);
        end
        $display("Errors: %0d, assertion failures: %0d, checks: %0d",
                 error_count, dut.sva.fail_count, check_count);
        if (error_count == 0 && dut.sva.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the total transaction count
    initial begin
        repeat (RESET_CYCLES + 50 * TOTAL_TXNS) @(posedge clk);
        $display("Timeout: run did not finish, %0d reads still outstanding", outstanding());
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
